/* testbench/matmul_cases.hex */
// each line holds five 32-bit words, lane 0 first
// per case: A columns 0-4 in load order, then B rows 0-4, then expected C rows 0-4
// case 0: upper triangle of ones gives prefix sums of A
00000001 00000006 0000000b 00000010 00000015
00000002 00000007 0000000c 00000011 00000016
00000003 00000008 0000000d 00000012 00000017
00000004 00000009 0000000e 00000013 00000018
00000005 0000000a 0000000f 00000014 00000019
00000001 00000001 00000001 00000001 00000001
00000000 00000001 00000001 00000001 00000001
00000000 00000000 00000001 00000001 00000001
00000000 00000000 00000000 00000001 00000001
00000000 00000000 00000000 00000000 00000001
00000001 00000003 00000006 0000000a 0000000f
00000006 0000000d 00000015 0000001e 00000028
0000000b 00000017 00000024 00000032 00000041
00000010 00000021 00000033 00000046 0000005a
00000015 0000002b 00000042 0000005a 00000073
// case 1: diagonal of minus one negates B
ffffffff 00000000 00000000 00000000 00000000
00000000 ffffffff 00000000 00000000 00000000
00000000 00000000 ffffffff 00000000 00000000
00000000 00000000 00000000 ffffffff 00000000
00000000 00000000 00000000 00000000 ffffffff
00000001 00000002 00000003 00000004 00000005
00000011 00000012 00000013 00000014 00000015
00000021 00000022 00000023 00000024 00000025
00000031 00000032 00000033 00000034 00000035
00000041 00000042 00000043 00000044 00000045
ffffffff fffffffe fffffffd fffffffc fffffffb
ffffffef ffffffee ffffffed ffffffec ffffffeb
ffffffdf ffffffde ffffffdd ffffffdc ffffffdb
ffffffcf ffffffce ffffffcd ffffffcc ffffffcb
ffffffbf ffffffbe ffffffbd ffffffbc ffffffbb
// case 2: sums wrap, C is minus (i+1)(j+1)
00000001 00000002 00000003 00000004 00000005
00000002 00000004 00000006 00000008 0000000a
00000003 00000006 00000009 0000000c 0000000f
00000004 00000008 0000000c 00000010 00000014
00000005 0000000a 0000000f 00000014 00000019
11111111 22222222 33333333 44444444 55555555
11111111 22222222 33333333 44444444 55555555
11111111 22222222 33333333 44444444 55555555
11111111 22222222 33333333 44444444 55555555
11111111 22222222 33333333 44444444 55555555
ffffffff fffffffe fffffffd fffffffc fffffffb
fffffffe fffffffc fffffffa fffffff8 fffffff6
fffffffd fffffffa fffffff7 fffffff4 fffffff1
fffffffc fffffff8 fffffff4 fffffff0 ffffffec
fffffffb fffffff6 fffffff1 ffffffec ffffffe7

/* files.f */
common/systolic_pkg.sv
common/array_ctrl_if.sv
verilog/lane_fifo.sv
verilog/operand_feeder.sv
systolic_array/processing_element.sv
systolic_array/systolic_array.sv
verilog/array_controller.sv
verilog/systolic_matmul.sv
testbench/systolic_matmul_assertions.sv
testbench/tb_systolic_matmul.sv

/* testbench/tb_systolic_matmul.sv */
`default_nettype none

module tb_systolic_matmul;

    localparam int DIM = systolic_pkg::DIM;
    localparam int NUM_CASES = 3;
    // A columns, B rows and C rows of one case
    localparam int CASE_WORDS = 3 * DIM * DIM;
    localparam int MAX_GAP = 3;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY = 1 + systolic_pkg::COMPUTE_CYCLES + 1;
    localparam int JOB_CYCLES = 2 + LATENCY + DIM + 2;
    localparam int LOAD_STEPS = DIM + NUM_CASES * DIM + DIM + (2 * DIM + 1) + 2 * DIM;
    localparam int NUM_JOBS = 1 + NUM_CASES + 1 + 2 + 2;
    localparam int START_TRIES = 2 * DIM * (MAX_GAP + 2);
    localparam int CYCLE_LIMIT =
        2 * (2 * RESET_CYCLES + LOAD_STEPS * (MAX_GAP + 2) + NUM_JOBS * JOB_CYCLES + 4 * DIM);

    logic                    clk;
    logic                    rst;
    logic                    load_en;
    systolic_pkg::lane_vec_t load_a;
    systolic_pkg::lane_vec_t load_b;
    logic                    load_full;
    logic                    start;
    logic                    busy;
    logic                    result_valid;
    systolic_pkg::lane_vec_t result_row;
    logic                    done;

    systolic_pkg::word_t case_mem [NUM_CASES*CASE_WORDS];
    int                  error_count;
    int                  check_count;
    int                  cycle_count;

    systolic_matmul u_dut (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_a       (load_a),
        .load_b       (load_b),
        .load_full    (load_full),
        .start        (start),
        .busy         (busy),
        .result_valid (result_valid),
        .result_row   (result_row),
        .done         (done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("checks: %0d errors: %0d", check_count, error_count + 1);
            $display("tests failed");
            $finish;
        end
    end

    function automatic systolic_pkg::lane_vec_t a_column(input int c, input int k);
        systolic_pkg::lane_vec_t v;
        for (int i = 0; i < DIM; i++) begin
            v[i] = case_mem[c*CASE_WORDS + k*DIM + i];
        end
        return v;
    endfunction

    function automatic systolic_pkg::lane_vec_t b_row(input int c, input int k);
        systolic_pkg::lane_vec_t v;
        for (int j = 0; j < DIM; j++) begin
            v[j] = case_mem[c*CASE_WORDS + DIM*DIM + k*DIM + j];
        end
        return v;
    endfunction

    function automatic systolic_pkg::lane_vec_t file_row(input int c, input int r);
        systolic_pkg::lane_vec_t v;
        for (int j = 0; j < DIM; j++) begin
            v[j] = case_mem[c*CASE_WORDS + 2*DIM*DIM + r*DIM + j];
        end
        return v;
    endfunction

    // row r of A times B, wrapping at the word width
    function automatic systolic_pkg::lane_vec_t model_row(input int c, input int r);
        systolic_pkg::lane_vec_t a_col;
        systolic_pkg::lane_vec_t b_k;
        systolic_pkg::lane_vec_t v;
        v = '0;
        for (int k = 0; k < DIM; k++) begin
            a_col = a_column(c, k);
            b_k   = b_row(c, k);
            for (int j = 0; j < DIM; j++) begin
                v[j] = v[j] + a_col[r] * b_k[j];
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input systolic_pkg::lane_vec_t got,
                               input systolic_pkg::lane_vec_t expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("FAIL %s: got %0h expected %0h", name, got, expected);
        end
    endtask

    task automatic verify_cases();
        assert (!$isunknown(case_mem[NUM_CASES*CASE_WORDS-1])) else begin
            error_count++;
            $display("the cases file holds fewer words than %0d cases need", NUM_CASES);
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            for (int r = 0; r < DIM; r++) begin
                assert (model_row(c, r) === file_row(c, r)) else begin
                    error_count++;
                    $display("case %0d: C row %0d in the cases file is not A times B", c, r);
                end
            end
        end
    endtask

    // waits for room, then one step and a random idle gap
    task automatic load_steps(input int c, input int first, input int last);
        int gap;
        for (int k = first; k <= last; k++) begin
            gap = $urandom_range(MAX_GAP, 0);
            @(negedge clk);
            while (load_full) begin
                @(negedge clk);
            end
            load_en = 1'b1;
            load_a  = a_column(c, k);
            load_b  = b_row(c, k);
            @(negedge clk);
            load_en = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic start_job(output bit accepted);
        accepted = 1'b0;
        for (int t = 0; t < START_TRIES && !accepted; t++) begin
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            accepted = busy;
        end
        assert (accepted) else begin
            error_count++;
            $display("start was not accepted after %0d tries", START_TRIES);
        end
    endtask

    task automatic collect_results(input int c);
        int lat;
        int r;
        lat = 0;
        while (!result_valid && lat < 2 * LATENCY) begin
            @(negedge clk);
            lat++;
        end
        assert (result_valid) else begin
            error_count++;
            $display("case %0d: result_valid never rose after start", c);
        end
        if (result_valid) begin
            check_value("result_valid latency", lat, LATENCY);
            // bottom row drains first
            for (int d = 0; d < DIM; d++) begin
                r = DIM - 1 - d;
                check_value($sformatf("result_row case %0d C row %0d", c, r),
                            result_row, file_row(c, r));
                check_value("result_valid", result_valid, 1'b1);
                check_value("done", done, d == DIM - 1);
                @(negedge clk);
            end
            check_value("result_valid", result_valid, 1'b0);
            check_value("busy", busy, 1'b0);
        end
    endtask

    task automatic run_job(input int c);
        bit ok;
        start_job(ok);
        if (ok) begin
            collect_results(c);
        end
    endtask

    initial begin
        bit ok;
        void'($urandom(31360));
        clk         = 1'b0;
        rst         = 1'b1;
        load_en     = 1'b0;
        load_a      = '0;
        load_b      = '0;
        start       = 1'b0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        $readmemh("testbench/matmul_cases.hex", case_mem);
        verify_cases();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // single multiply
        load_steps(0, 0, DIM - 1);
        run_job(0);

        // back to back, later cases fill in while earlier jobs run
        load_steps(0, 0, DIM - 1);
        load_steps(1, 0, 2);
        fork
            begin
                run_job(0);
                run_job(1);
                run_job(2);
            end
            begin
                load_steps(1, 3, DIM - 1);
                load_steps(2, 0, DIM - 1);
            end
        join

        // start with only three steps loaded
        load_steps(2, 0, 2);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (DIM) begin
            check_value("busy", busy, 1'b0);
            check_value("result_valid", result_valid, 1'b0);
            @(negedge clk);
        end
        load_steps(2, 3, DIM - 1);
        run_job(2);

        // eight steps fill the fifos, the ninth is dropped
        load_steps(1, 0, DIM - 1);
        load_steps(2, 0, 2);
        check_value("load_full", load_full, 1'b1);
        load_en = 1'b1;
        load_a  = a_column(0, 0);
        load_b  = b_row(0, 0);
        @(negedge clk);
        load_en = 1'b0;
        check_value("load_full", load_full, 1'b1);
        run_job(1);
        load_steps(2, 3, DIM - 1);
        run_job(2);

        // reset while the fifos are still being popped
        load_steps(1, 0, DIM - 1);
        start_job(ok);
        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 1'b0);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // the aborted job never drains
        repeat (LATENCY + DIM) begin
            check_value("busy", busy, 1'b0);
            check_value("result_valid", result_valid, 1'b0);
            @(negedge clk);
        end
        load_steps(0, 0, DIM - 1);
        run_job(0);

        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/systolic_matmul_assertions.sv */
`default_nettype none

module systolic_matmul_assertions (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic result_valid,
    input logic done,
    input logic load_full,
    input logic operands_ready
);

    // done rides on the last drain row
    done_with_row: assert property (@(posedge clk) disable iff (rst)
        done |-> result_valid && $past(result_valid, systolic_pkg::DIM - 1))
        else $error("done high without the last result row");

    drain_length: assert property (@(posedge clk) disable iff (rst)
        $rose(result_valid) |-> result_valid [*systolic_pkg::DIM] ##1 !result_valid)
        else $error("result_valid did not last exactly DIM cycles");

    valid_in_job: assert property (@(posedge clk) disable iff (rst)
        $rose(result_valid) |-> busy && $past(busy))
        else $error("result_valid rose outside a running job");

    // a full set of fifos always holds a whole job
    full_not_empty: assert property (@(posedge clk) disable iff (rst)
        load_full |-> operands_ready)
        else $error("load_full high while the fifos lack a whole job");

endmodule

bind systolic_matmul systolic_matmul_assertions u_assertions (
    .clk            (clk),
    .rst            (rst),
    .busy           (busy),
    .result_valid   (result_valid),
    .done           (done),
    .load_full      (load_full),
    .operands_ready (operands_ready)
);

`default_nettype wire

/* verilog/systolic_matmul.sv */
`default_nettype none

module systolic_matmul (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_en,
    input  systolic_pkg::lane_vec_t load_a,
    input  systolic_pkg::lane_vec_t load_b,
    output logic                    load_full,
    input  logic                    start,
    output logic                    busy,
    output logic                    result_valid,
    output systolic_pkg::lane_vec_t result_row,
    output logic                    done
);

    logic                    pop;
    logic                    operands_ready;
    systolic_pkg::lane_vec_t a_edge;
    systolic_pkg::lane_vec_t b_edge;

    array_ctrl_if u_ctrl_if ();

    operand_feeder u_feeder (
        .clk            (clk),
        .rst            (rst),
        .load_en        (load_en),
        .load_a         (load_a),
        .load_b         (load_b),
        .load_full      (load_full),
        .pop            (pop),
        .operands_ready (operands_ready),
        .a_edge         (a_edge),
        .b_edge         (b_edge)
    );

    array_controller u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .operands_ready (operands_ready),
        .pop            (pop),
        .busy           (busy),
        .result_valid   (result_valid),
        .done           (done),
        .ctrl           (u_ctrl_if.controller)
    );

    systolic_array u_array (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (u_ctrl_if.grid),
        .a_edge     (a_edge),
        .b_edge     (b_edge),
        .result_row (result_row)
    );

endmodule

`default_nettype wire

/* verilog/array_controller.sv */
`default_nettype none

module array_controller (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             operands_ready,
    output logic             pop,
    output logic             busy,
    output logic             result_valid,
    output logic             done,
    array_ctrl_if.controller ctrl
);

    systolic_pkg::ctrl_state_t state;
    systolic_pkg::ctrl_state_t state_next;
    systolic_pkg::phase_cnt_t  phase_cnt;
    logic                      counting;

    always_comb begin
        state_next = state;
        case (state)
            systolic_pkg::IDLE: begin
                if (start && operands_ready) begin
                    state_next = systolic_pkg::CLEAR;
                end
            end
            systolic_pkg::CLEAR: begin
                state_next = systolic_pkg::COMPUTE;
            end
            systolic_pkg::COMPUTE: begin
                if (phase_cnt == systolic_pkg::phase_cnt_t'(systolic_pkg::COMPUTE_CYCLES - 1)) begin
                    state_next = systolic_pkg::LOAD;
                end
            end
            systolic_pkg::LOAD: begin
                state_next = systolic_pkg::DRAIN;
            end
            systolic_pkg::DRAIN: begin
                // DONE carries the last of the DIM drain rows
                if (phase_cnt == systolic_pkg::phase_cnt_t'(systolic_pkg::DIM - 2)) begin
                    state_next = systolic_pkg::DONE;
                end
            end
            systolic_pkg::DONE: begin
                state_next = systolic_pkg::IDLE;
            end
            default: begin
                state_next = systolic_pkg::IDLE;
            end
        endcase
    end

    // counter restarts on every phase change
    assign counting = (state_next == state) &&
                      (state == systolic_pkg::COMPUTE || state == systolic_pkg::DRAIN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= systolic_pkg::IDLE;
            phase_cnt <= '0;
        end else begin
            state     <= state_next;
            phase_cnt <= counting ? phase_cnt + 1'b1 : '0;
        end
    end

    assign ctrl.clear       = (state == systolic_pkg::CLEAR);
    assign ctrl.compute     = (state == systolic_pkg::COMPUTE);
    assign ctrl.drain_load  = (state == systolic_pkg::LOAD);
    assign ctrl.drain_shift = (state == systolic_pkg::DRAIN) || (state == systolic_pkg::DONE);

    // one word per lane for the first DIM compute cycles
    assign pop = (state == systolic_pkg::COMPUTE) &&
                 (phase_cnt < systolic_pkg::phase_cnt_t'(systolic_pkg::DIM));

    assign busy         = (state != systolic_pkg::IDLE);
    assign result_valid = (state == systolic_pkg::DRAIN) || (state == systolic_pkg::DONE);
    assign done         = (state == systolic_pkg::DONE);

endmodule

`default_nettype wire

/* systolic_array/systolic_array.sv */
`default_nettype none

module systolic_array (
    input  logic                    clk,
    input  logic                    rst,
    array_ctrl_if.grid              ctrl,
    input  systolic_pkg::lane_vec_t a_edge,
    input  systolic_pkg::lane_vec_t b_edge,
    output systolic_pkg::lane_vec_t result_row
);

    // a_link[r][c] feeds cell (r,c) from the left, last column leaves the grid
    systolic_pkg::word_t a_link [systolic_pkg::DIM][systolic_pkg::DIM+1];
    // b_link[r][c] feeds cell (r,c) from above, last row is the drain output
    systolic_pkg::word_t b_link [systolic_pkg::DIM+1][systolic_pkg::DIM];

    for (genvar r = 0; r < systolic_pkg::DIM; r++) begin : g_row
        assign a_link[r][0] = a_edge[r];

        for (genvar c = 0; c < systolic_pkg::DIM; c++) begin : g_col
            processing_element u_pe (
                .clk   (clk),
                .rst   (rst),
                .ctrl  (ctrl),
                .a_in  (a_link[r][c]),
                .b_in  (b_link[r][c]),
                .a_out (a_link[r][c+1]),
                .b_out (b_link[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < systolic_pkg::DIM; c++) begin : g_edge
        assign b_link[0][c]  = b_edge[c];
        assign result_row[c] = b_link[systolic_pkg::DIM][c];
    end

endmodule

`default_nettype wire

/* systolic_array/processing_element.sv */
`default_nettype none

module processing_element (
    input  logic                clk,
    input  logic                rst,
    array_ctrl_if.grid          ctrl,
    input  systolic_pkg::word_t a_in,
    input  systolic_pkg::word_t b_in,
    output systolic_pkg::word_t a_out,
    output systolic_pkg::word_t b_out
);

    systolic_pkg::word_t acc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (ctrl.clear) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (ctrl.compute) begin
            // product wraps to the word width
            acc   <= acc + a_in * b_in;
            a_out <= a_in;
            b_out <= b_in;
        end else if (ctrl.drain_load) begin
            b_out <= acc;
        end else if (ctrl.drain_shift) begin
            // result column moves one row down
            b_out <= b_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/operand_feeder.sv */
`default_nettype none

module operand_feeder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_en,
    input  systolic_pkg::lane_vec_t load_a,
    input  systolic_pkg::lane_vec_t load_b,
    output logic                    load_full,
    input  logic                    pop,
    output logic                    operands_ready,
    output systolic_pkg::lane_vec_t a_edge,
    output systolic_pkg::lane_vec_t b_edge
);

    // index 0 is the A side, index 1 the B side
    systolic_pkg::lane_vec_t        load_data [2];
    systolic_pkg::lane_vec_t        tap_data [2];
    logic [systolic_pkg::DIM-1:0]   tap_valid [2];
    systolic_pkg::lane_vec_t        edge_q [2];
    logic [2*systolic_pkg::DIM-1:0] lane_full;
    logic [2*systolic_pkg::DIM-1:0] lane_ready;
    logic                           wr_en;
    logic                           rd_valid;

    assign load_data[0] = load_a;
    assign load_data[1] = load_b;

    // a step is taken on all ten lanes or on none
    assign load_full      = |lane_full;
    assign wr_en          = load_en && !load_full;
    assign operands_ready = &lane_ready;

    // marks the cycle the fifo read data is fresh
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop;
        end
    end

    for (genvar s = 0; s < 2; s++) begin : g_side
        for (genvar i = 0; i < systolic_pkg::DIM; i++) begin : g_lane
            systolic_pkg::word_t     fifo_q;
            systolic_pkg::fifo_cnt_t fifo_count;
            logic                    fifo_full;

            lane_fifo u_fifo (
                .clk     (clk),
                .rst     (rst),
                .wr_en   (wr_en),
                .wr_data (load_data[s][i]),
                .rd_en   (pop),
                .rd_data (fifo_q),
                .count   (fifo_count),
                .full    (fifo_full),
                .empty   ()
            );

            assign lane_full[s*systolic_pkg::DIM+i]  = fifo_full;
            assign lane_ready[s*systolic_pkg::DIM+i] =
                (fifo_count >= systolic_pkg::fifo_cnt_t'(systolic_pkg::DIM));

            if (i == 0) begin : g_direct
                assign tap_data[s][i]  = fifo_q;
                assign tap_valid[s][i] = rd_valid;
            end else begin : g_skew
                // lane i lags lane 0 by i cycles
                systolic_pkg::word_t chain_data [i];
                logic [i-1:0]        chain_valid;

                always_ff @(posedge clk or posedge rst) begin
                    if (rst) begin
                        chain_valid <= '0;
                    end else begin
                        chain_valid[0] <= rd_valid;
                        for (int k = 1; k < i; k++) begin
                            chain_valid[k] <= chain_valid[k-1];
                        end
                    end
                end

                always_ff @(posedge clk) begin
                    chain_data[0] <= fifo_q;
                    for (int k = 1; k < i; k++) begin
                        chain_data[k] <= chain_data[k-1];
                    end
                end

                assign tap_data[s][i]  = chain_data[i-1];
                assign tap_valid[s][i] = chain_valid[i-1];
            end
        end
    end

    // edge register, idle lanes feed zeros into the grid
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < systolic_pkg::DIM; i++) begin
                edge_q[s][i] <= tap_valid[s][i] ? tap_data[s][i] : '0;
            end
        end
    end

    assign a_edge = edge_q[0];
    assign b_edge = edge_q[1];

endmodule

`default_nettype wire

/* verilog/lane_fifo.sv */
`default_nettype none

module lane_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  systolic_pkg::word_t     wr_data,
    input  logic                    rd_en,
    output systolic_pkg::word_t     rd_data,
    output systolic_pkg::fifo_cnt_t count,
    output logic                    full,
    output logic                    empty
);

    systolic_pkg::word_t     mem [systolic_pkg::FIFO_DEPTH];
    systolic_pkg::fifo_ptr_t wr_ptr;
    systolic_pkg::fifo_ptr_t rd_ptr;
    logic                    do_wr;
    logic                    do_rd;

    assign full  = (count == systolic_pkg::fifo_cnt_t'(systolic_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // overflow writes and underflow reads are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == systolic_pkg::fifo_ptr_t'(systolic_pkg::FIFO_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == systolic_pkg::fifo_ptr_t'(systolic_pkg::FIFO_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // read data is registered and holds between reads
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* common/array_ctrl_if.sv */
`default_nettype none

interface array_ctrl_if;

    // at most one of these is high in any cycle
    logic clear;
    logic compute;
    logic drain_load;
    logic drain_shift;

    modport controller (
        output clear,
        output compute,
        output drain_load,
        output drain_shift
    );

    modport grid (
        input clear,
        input compute,
        input drain_load,
        input drain_shift
    );

endinterface

`default_nettype wire

/* common/systolic_pkg.sv */
`default_nettype none

package systolic_pkg;

    // grid size, also the inner dimension of one job
    localparam int DIM = 5;
    localparam int WORD_W = 32;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // inner steps + skew across the grid + fifo read reg + edge reg
    localparam int COMPUTE_CYCLES = DIM + 2 * DIM - 2 + 2;
    localparam int PHASE_CNT_W = $clog2(COMPUTE_CYCLES);

    typedef logic [WORD_W-1:0] word_t;

    // one word per lane, lane 0 in the low bits
    typedef logic [DIM-1:0][WORD_W-1:0] lane_vec_t;

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
    typedef logic [PHASE_CNT_W-1:0] phase_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        COMPUTE,
        LOAD,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire
